// File: cp0_defines.svh
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// cp0 register numbers, select 0 only
`define CP0_BADVADDR_NUM 5'd8
`define CP0_COUNT_NUM    5'd9
`define CP0_COMPARE_NUM  5'd11
`define CP0_STATUS_NUM   5'd12
`define CP0_CAUSE_NUM    5'd13
`define CP0_EPC_NUM      5'd14

// general exception entry with BEV=1
`define CP0_EXC_VECTOR 32'hBFC00380

// axi4-lite address width
`define CP0_AXIL_AW 12

`endif

// File: cp0_pkg.sv
`default_nettype none

package cp0_pkg;

	// one register access from the bus side
	typedef struct packed {
		logic        wen;
		logic        ren;
		logic [4:0]  reg_num;
		logic [2:0]  sel;
		logic [31:0] wdata;
	} cp0_req_t;

	typedef struct packed {
		logic [8:0] rsv0;
		logic       bev;
		logic [5:0] rsv1;
		logic [7:0] im;
		logic [5:0] rsv2;
		logic       exl;
		logic       ie;
	} status_t;

	typedef struct packed {
		logic        bd;
		logic        ti;
		logic [13:0] rsv0;
		logic [7:0]  ip;
		logic        rsv1;
		logic [4:0]  exccode;
		logic [1:0]  rsv2;
	} cause_t;

endpackage

`default_nettype wire

// File: exc_pkg.sv
`default_nettype none

package exc_pkg;

	typedef enum logic [4:0] {
		EXC_INT  = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10,
		EXC_OV   = 5'd12
	} exccode_e;

	// intr is the interrupt flag
	typedef struct packed {
		logic intr;
		logic rine;
		logic rdae;
		logic ades;
		logic sys;
		logic bp;
		logic ri;
		logic ov;
	} exc_flags_t;

	// report from the pipeline
	typedef struct packed {
		logic        valid;
		exc_flags_t  flags;
		logic [31:0] pc;
		logic        is_slot;
		logic [31:0] bad_vaddr;
		logic        eret;
	} exc_report_t;

	typedef struct packed {
		logic        take;
		logic        eret;
		exccode_e    exccode;
		logic        addr_err;
		logic [31:0] pc;
		logic        is_slot;
		logic [31:0] bad_vaddr;
	} exc_event_t;

endpackage

`default_nettype wire

// File: cp0_axil_slave.sv
`default_nettype none

`include "cp0_defines.svh"

module cp0_axil_slave (
	input  wire                       clk,
	input  wire                       rst,

	input  wire [`CP0_AXIL_AW-1:0]    awaddr,
	input  wire                       awvalid,
	output logic                      awready,
	input  wire [31:0]                wdata,
	input  wire [3:0]                 wstrb,
	input  wire                       wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  wire                       bready,

	input  wire [`CP0_AXIL_AW-1:0]    araddr,
	input  wire                       arvalid,
	output logic                      arready,
	output logic [31:0]               rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  wire                       rready,

	output cp0_pkg::cp0_req_t         req,
	input  wire [31:0]                rdata_word
);

	logic wr_acc;
	logic rd_acc;

	// address and data must both be present, one response in flight
	assign wr_acc  = awvalid && wvalid && !bvalid;
	// a write in the same cycle holds the read off
	assign rd_acc  = arvalid && !rvalid && !wr_acc;

	assign awready = wr_acc;
	assign wready  = wr_acc;
	assign arready = !rvalid && !wr_acc;

	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// word offset is {reg_num, sel}
	always_comb begin
		req       = '0;
		req.wdata = wdata;
		if (wr_acc) begin
			req.wen     = 1'b1;
			req.reg_num = awaddr[9:5];
			req.sel     = awaddr[4:2];
		end else if (rd_acc) begin
			req.ren     = 1'b1;
			req.reg_num = araddr[9:5];
			req.sel     = araddr[4:2];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			bvalid <= 1'b0;
		else if (wr_acc)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst)
			rvalid <= 1'b0;
		else if (rd_acc)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rd_acc)
			rdata <= rdata_word;
	end

endmodule

`default_nettype wire

// File: exc_prioritizer.sv
`default_nettype none

module exc_prioritizer (
	input  wire                   clk,
	input  wire                   rst,
	input  exc_pkg::exc_report_t  report,
	input  wire                   int_pending,
	output exc_pkg::exc_event_t   event_out
);

	exc_pkg::exc_flags_t flags;
	exc_pkg::exc_event_t event_d;
	logic                any_exc;

	always_comb begin
		flags = report.flags;
		// pending interrupt rides on the next valid report
		flags.intr = report.flags.intr | (report.valid & int_pending);
	end

	assign any_exc = report.valid && (|flags);

	always_comb begin
		event_d           = '0;
		event_d.take      = any_exc;
		// eret is dropped when an exception is taken in the same report
		event_d.eret      = report.valid && report.eret && !any_exc;
		event_d.addr_err  = flags.rine | flags.rdae | flags.ades;
		event_d.pc        = report.pc;
		event_d.is_slot   = report.is_slot;
		event_d.bad_vaddr = report.bad_vaddr;
		if (flags.intr)
			event_d.exccode = exc_pkg::EXC_INT;
		else if (flags.rine)
			event_d.exccode = exc_pkg::EXC_ADEL;
		else if (flags.ri)
			event_d.exccode = exc_pkg::EXC_RI;
		else if (flags.sys)
			event_d.exccode = exc_pkg::EXC_SYS;
		else if (flags.bp)
			event_d.exccode = exc_pkg::EXC_BP;
		else if (flags.ov)
			event_d.exccode = exc_pkg::EXC_OV;
		else if (flags.rdae)
			event_d.exccode = exc_pkg::EXC_ADEL;
		else
			event_d.exccode = exc_pkg::EXC_ADES;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			event_out.take <= 1'b0;
			event_out.eret <= 1'b0;
		end else begin
			event_out.take <= event_d.take;
			event_out.eret <= event_d.eret;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		event_out.exccode   <= event_d.exccode;
		event_out.addr_err  <= event_d.addr_err;
		event_out.pc        <= event_d.pc;
		event_out.is_slot   <= event_d.is_slot;
		event_out.bad_vaddr <= event_d.bad_vaddr;
	end

endmodule

`default_nettype wire

// File: cp0_regs.sv
`default_nettype none

`include "cp0_defines.svh"

module cp0_regs (
	input  wire                   clk,
	input  wire                   rst,
	input  cp0_pkg::cp0_req_t     req,
	output logic [31:0]           rdata_word,
	input  exc_pkg::exc_event_t   event_in,
	input  wire [5:0]             int_lines,
	output logic [31:0]           epc,
	output logic                  int_pending
);

	cp0_pkg::status_t status;
	cp0_pkg::cause_t  cause;

	logic [7:0]  status_im;
	logic        status_exl;
	logic        status_ie;
	logic        cause_bd;
	logic        cause_ti;
	logic [7:0]  cause_ip;
	logic [4:0]  cause_exccode;
	logic [31:0] epc_q;
	logic [31:0] badvaddr;
	logic [32:0] count;
	logic [31:0] compare;

	logic        sel0;
	logic        wr_status;
	logic        wr_cause;
	logic        wr_epc;
	logic        wr_count;
	logic        wr_compare;

	assign sel0       = req.sel == 3'd0;
	assign wr_status  = req.wen && sel0 && req.reg_num == `CP0_STATUS_NUM;
	assign wr_cause   = req.wen && sel0 && req.reg_num == `CP0_CAUSE_NUM;
	assign wr_epc     = req.wen && sel0 && req.reg_num == `CP0_EPC_NUM;
	assign wr_count   = req.wen && sel0 && req.reg_num == `CP0_COUNT_NUM;
	assign wr_compare = req.wen && sel0 && req.reg_num == `CP0_COMPARE_NUM;

	always_comb begin
		status      = '0;
		status.bev  = 1'b1;
		status.im   = status_im;
		status.exl  = status_exl;
		status.ie   = status_ie;
		cause         = '0;
		cause.bd      = cause_bd;
		cause.ti      = cause_ti;
		cause.ip      = cause_ip;
		cause.exccode = cause_exccode;
	end

	always_comb begin
		rdata_word = 32'd0;
		if (req.ren && sel0) begin
			case (req.reg_num)
				`CP0_BADVADDR_NUM: rdata_word = badvaddr;
				`CP0_COUNT_NUM:    rdata_word = count[32:1];
				`CP0_COMPARE_NUM:  rdata_word = compare;
				`CP0_STATUS_NUM:   rdata_word = status;
				`CP0_CAUSE_NUM:    rdata_word = cause;
				`CP0_EPC_NUM:      rdata_word = epc_q;
				default:           rdata_word = 32'd0;
			endcase
		end
	end

	assign epc = epc_q;
	assign int_pending = !status_exl && status_ie && (|(status_im & cause_ip));

	always_ff @(posedge clk) begin
		if (rst) begin
			status_im  <= 8'd0;
			status_ie  <= 1'b0;
			status_exl <= 1'b0;
		end else begin
			if (wr_status) begin
				status_im <= req.wdata[15:8];
				status_ie <= req.wdata[0];
			end
			// take beats eret beats software
			if (event_in.take)
				status_exl <= 1'b1;
			else if (event_in.eret)
				status_exl <= 1'b0;
			else if (wr_status)
				status_exl <= req.wdata[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cause_bd      <= 1'b0;
			cause_ti      <= 1'b0;
			cause_ip      <= 8'd0;
			cause_exccode <= 5'd0;
		end else begin
			if (event_in.take && !status_exl)
				cause_bd <= event_in.is_slot;
			if (wr_compare)
				cause_ti <= 1'b0;
			else if (count[32:1] == compare)
				cause_ti <= 1'b1;
			// hw lines sampled every cycle, timer shares ip7
			cause_ip[7:2] <= {int_lines[5] | cause_ti, int_lines[4:0]};
			if (wr_cause)
				cause_ip[1:0] <= req.wdata[9:8];
			if (event_in.take)
				cause_exccode <= event_in.exccode;
		end
	end

	// nested exceptions keep the first epc
	always_ff @(posedge clk) begin
		if (event_in.take && !status_exl)
			epc_q <= event_in.is_slot ? event_in.pc - 32'd4 : event_in.pc;
		else if (wr_epc)
			epc_q <= req.wdata;
	end

	always_ff @(posedge clk) begin
		if (event_in.take && event_in.addr_err)
			badvaddr <= event_in.bad_vaddr;
	end

	// bit 0 halves the count rate
	always_ff @(posedge clk) begin
		if (rst)
			count <= 33'd0;
		else if (wr_count)
			count <= {req.wdata, 1'b0};
		else
			count <= count + 33'd1;
	end

	always_ff @(posedge clk) begin
		if (wr_compare)
			compare <= req.wdata;
	end

endmodule

`default_nettype wire

// File: exc_redirect.sv
`default_nettype none

`include "cp0_defines.svh"

module exc_redirect (
	input  wire                   clk,
	input  wire                   rst,
	input  exc_pkg::exc_event_t   event_in,
	input  wire [31:0]            epc,
	output logic                  flush,
	output logic [31:0]           redirect_pc
);

	logic        redirect;
	logic [31:0] target;

	assign redirect = event_in.take || event_in.eret;

	// epc is still the old value here, eret leaves it alone anyway
	assign target = event_in.take ? `CP0_EXC_VECTOR : epc;

	// one pulse per event, events never come back to back from one report
	always_ff @(posedge clk) begin
		if (rst)
			flush <= 1'b0;
		else
			flush <= redirect;
	end

	always_ff @(posedge clk) begin
		if (redirect)
			redirect_pc <= target;
	end

endmodule

`default_nettype wire

// File: cp0_top.sv
`default_nettype none

`include "cp0_defines.svh"

module cp0_top (
	input  wire                       clk,
	input  wire                       rst,

	input  wire [`CP0_AXIL_AW-1:0]    awaddr,
	input  wire                       awvalid,
	output logic                      awready,
	input  wire [31:0]                wdata,
	input  wire [3:0]                 wstrb,
	input  wire                       wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  wire                       bready,
	input  wire [`CP0_AXIL_AW-1:0]    araddr,
	input  wire                       arvalid,
	output logic                      arready,
	output logic [31:0]               rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  wire                       rready,

	input  exc_pkg::exc_report_t      report,
	input  wire [5:0]                 int_lines,
	output logic                      flush,
	output logic [31:0]               redirect_pc,
	output logic [31:0]               epc,
	output logic                      int_pending
);

	cp0_pkg::cp0_req_t   req;
	logic [31:0]         rdata_word;
	exc_pkg::exc_event_t exc_event;

	cp0_axil_slave u_axil (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.req(req), .rdata_word(rdata_word)
	);

	exc_prioritizer u_prio (
		.clk(clk), .rst(rst),
		.report(report), .int_pending(int_pending), .event_out(exc_event)
	);

	cp0_regs u_regs (
		.clk(clk), .rst(rst),
		.req(req), .rdata_word(rdata_word), .event_in(exc_event),
		.int_lines(int_lines), .epc(epc), .int_pending(int_pending)
	);

	exc_redirect u_redirect (
		.clk(clk), .rst(rst),
		.event_in(exc_event), .epc(epc),
		.flush(flush), .redirect_pc(redirect_pc)
	);

endmodule

`default_nettype wire

// File: tb_cp0_tasks.svh
`ifndef TB_CP0_TASKS_SVH
`define TB_CP0_TASKS_SVH

// galois lfsr, one step per bit taken
task automatic rand_bits(input int n, output int v);
	int i;
	v = 0;
	for (i = 0; i < n; i++) begin
		v = (v << 1) | {31'd0, lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
	end
endtask

task automatic stall_cycles();
	int k;
	rand_bits(2, k);
	repeat (k) begin
		@(posedge clk);
		#DRV;
	end
endtask

task automatic axi_write(input logic [4:0] reg_num, input logic [2:0] sel,
		input logic [31:0] data);
	int n;
	n = 0;
	awaddr  = addr_of(reg_num, sel);
	wdata   = data;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	@(negedge clk);
	while (!awready) begin
		n++;
		if (n > TMO)
			abort_on_timeout("awready");
		@(negedge clk);
	end
	@(posedge clk);
	#DRV;
	awvalid = 1'b0;
	wvalid  = 1'b0;
	stall_cycles();
	bready = 1'b1;
	n = 0;
	@(negedge clk);
	while (!bvalid) begin
		n++;
		if (n > TMO)
			abort_on_timeout("bvalid");
		@(negedge clk);
	end
	@(posedge clk);
	#DRV;
	bready = 1'b0;
endtask

// chk enables the rdata comparison against exp
task automatic axi_read(input logic [4:0] reg_num, input logic [2:0] sel,
		input logic chk, input logic [31:0] exp, output logic [31:0] data);
	int n;
	n = 0;
	rd_chk    = chk;
	// epc port has to match an EPC read
	rd_epc    = chk && reg_num == `CP0_EPC_NUM && sel == 3'd0;
	exp_rdata = exp;
	araddr    = addr_of(reg_num, sel);
	arvalid   = 1'b1;
	@(negedge clk);
	while (!arready) begin
		n++;
		if (n > TMO)
			abort_on_timeout("arready");
		@(negedge clk);
	end
	@(posedge clk);
	#DRV;
	arvalid = 1'b0;
	stall_cycles();
	rready = 1'b1;
	n = 0;
	@(negedge clk);
	while (!rvalid) begin
		n++;
		if (n > TMO)
			abort_on_timeout("rvalid");
		@(negedge clk);
	end
	data = rdata;
	@(posedge clk);
	#DRV;
	rready = 1'b0;
	rd_chk = 1'b0;
	rd_epc = 1'b0;
endtask

// one-cycle report, then wait for the flush it causes
task automatic send_report(input logic [7:0] flags, input logic [31:0] pc,
		input logic is_slot, input logic [31:0] bva, input logic eret,
		input logic [31:0] target);
	int n;
	n = 0;
	exp_redir     = target;
	rep           = '0;
	rep.valid     = 1'b1;
	rep.flags     = flags;
	rep.pc        = pc;
	rep.is_slot   = is_slot;
	rep.bad_vaddr = bva;
	rep.eret      = eret;
	@(posedge clk);
	#DRV;
	rep = '0;
	@(negedge clk);
	while (!flush) begin
		n++;
		if (n > TMO)
			abort_on_timeout("flush");
		@(negedge clk);
	end
	@(posedge clk);
	#DRV;
endtask

task automatic wait_int_pending();
	int n;
	n = 0;
	@(negedge clk);
	while (!int_pending) begin
		n++;
		if (n > TMO)
			abort_on_timeout("int_pending");
		@(negedge clk);
	end
	@(posedge clk);
	#DRV;
endtask

`endif

// File: tb_cp0_top.sv
`default_nettype none

`include "cp0_defines.svh"

module tb_cp0_top;

	localparam int DRV = 5;
	localparam int TMO = 50;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	localparam logic [31:0] VEC = `CP0_EXC_VECTOR;

	logic clk;
	logic rst;
	logic [`CP0_AXIL_AW-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`CP0_AXIL_AW-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	exc_pkg::exc_report_t rep;
	logic [5:0] int_lines;
	logic flush;
	logic [31:0] redirect_pc;
	logic [31:0] epc;
	logic int_pending;

	logic [31:0] lfsr = 32'h0468ffac;
	logic rd_chk;
	logic rd_epc;
	logic [31:0] exp_rdata;
	logic [31:0] exp_redir;
	logic int_armed;
	int errors = 0;
	int timeouts = 0;

	cp0_top UUT (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.report(rep), .int_lines(int_lines), .flush(flush),
		.redirect_pc(redirect_pc), .epc(epc), .int_pending(int_pending)
	);

	function automatic logic [`CP0_AXIL_AW-1:0] addr_of(input logic [4:0] r,
			input logic [2:0] s);
		return {2'b00, r, s, 2'b00};
	endfunction

	function automatic logic [31:0] status_word(input logic [7:0] im,
			input logic exl, input logic ie);
		cp0_pkg::status_t s;
		s     = '0;
		s.bev = 1'b1;
		s.im  = im;
		s.exl = exl;
		s.ie  = ie;
		return s;
	endfunction

	function automatic logic [31:0] cause_word(input logic bd, input logic ti,
			input logic [7:0] ip, input logic [4:0] code);
		cp0_pkg::cause_t c;
		c         = '0;
		c.bd      = bd;
		c.ti      = ti;
		c.ip      = ip;
		c.exccode = code;
		return c;
	endfunction

	task automatic finish_run();
		$display("checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout: no %s within %0d cycles, stopping the run", what, TMO);
		timeouts++;
	endtask

	`include "tb_cp0_tasks.svh"

	task automatic run_scenario();
		logic [31:0] d;
		logic [31:0] last_epc;
		logic [31:0] cnt;
		int n;

		// register access
		axi_write(`CP0_COMPARE_NUM, 3'd0, 32'hFFFF0000);
		axi_read(`CP0_COMPARE_NUM, 3'd0, 1'b1, 32'hFFFF0000, d);
		axi_write(`CP0_STATUS_NUM, 3'd0, 32'hFFFFAA02);
		axi_read(`CP0_STATUS_NUM, 3'd0, 1'b1, status_word(8'hAA, 1'b1, 1'b0), d);
		axi_write(`CP0_EPC_NUM, 3'd0, 32'h12345678);
		axi_write(`CP0_EPC_NUM, 3'd1, 32'hCAFEF00D);
		axi_read(`CP0_EPC_NUM, 3'd0, 1'b1, 32'h12345678, d);
		axi_read(`CP0_STATUS_NUM, 3'd3, 1'b1, 32'd0, d);
		axi_read(`CP0_EPC_NUM, 3'd1, 1'b1, 32'd0, d);
		axi_write(`CP0_STATUS_NUM, 3'd0, 32'd0);

		// address error in a delay slot
		send_report(8'h10, 32'h80002000, 1'b1, 32'hDEAD0004, 1'b0, VEC);
		axi_read(`CP0_CAUSE_NUM, 3'd0, 1'b1, cause_word(1'b1, 1'b0, 8'd0, 5'd5), d);
		axi_read(`CP0_EPC_NUM, 3'd0, 1'b1, 32'h80001FFC, d);
		axi_read(`CP0_BADVADDR_NUM, 3'd0, 1'b1, 32'hDEAD0004, d);
		axi_read(`CP0_STATUS_NUM, 3'd0, 1'b1, status_word(8'd0, 1'b1, 1'b0), d);
		axi_write(`CP0_STATUS_NUM, 3'd0, 32'd0);

		// ri beats ov, badvaddr untouched
		send_report(8'h03, 32'h80001000, 1'b0, 32'h55550000, 1'b0, VEC);
		axi_read(`CP0_CAUSE_NUM, 3'd0, 1'b1, cause_word(1'b0, 1'b0, 8'd0, 5'd10), d);
		axi_read(`CP0_EPC_NUM, 3'd0, 1'b1, 32'h80001000, d);
		axi_read(`CP0_BADVADDR_NUM, 3'd0, 1'b1, 32'hDEAD0004, d);

		// nested
		send_report(8'h08, 32'h80003000, 1'b1, 32'd0, 1'b0, VEC);
		axi_read(`CP0_CAUSE_NUM, 3'd0, 1'b1, cause_word(1'b0, 1'b0, 8'd0, 5'd8), d);
		axi_read(`CP0_EPC_NUM, 3'd0, 1'b1, 32'h80001000, last_epc);

		// eret
		send_report(8'h00, 32'h80005000, 1'b0, 32'd0, 1'b1, last_epc);
		axi_read(`CP0_STATUS_NUM, 3'd0, 1'b1, status_word(8'd0, 1'b0, 1'b0), d);

		// hardware interrupt on ip2
		int_lines = 6'b000001;
		axi_write(`CP0_STATUS_NUM, 3'd0, 32'h00000401);
		axi_read(`CP0_STATUS_NUM, 3'd0, 1'b1, status_word(8'h04, 1'b0, 1'b1), d);
		wait_int_pending();
		int_armed = 1'b1;
		repeat (2) @(posedge clk);
		#DRV;
		int_armed = 1'b0;
		send_report(8'h00, 32'h80004000, 1'b0, 32'd0, 1'b0, VEC);
		axi_read(`CP0_CAUSE_NUM, 3'd0, 1'b1, cause_word(1'b0, 1'b0, 8'h04, 5'd0), d);
		axi_read(`CP0_EPC_NUM, 3'd0, 1'b1, 32'h80004000, d);
		int_lines = 6'd0;
		axi_write(`CP0_STATUS_NUM, 3'd0, 32'd0);

		// timer
		axi_read(`CP0_COUNT_NUM, 3'd0, 1'b0, 32'd0, cnt);
		axi_write(`CP0_COMPARE_NUM, 3'd0, cnt + 32'd40);
		axi_write(`CP0_STATUS_NUM, 3'd0, 32'h00008001);
		n = 0;
		d = 32'd0;
		while (!d[30]) begin
			n++;
			if (n > TMO)
				abort_on_timeout("Cause TI");
			axi_read(`CP0_CAUSE_NUM, 3'd0, 1'b0, 32'd0, d);
		end
		wait_int_pending();
		int_armed = 1'b1;
		repeat (2) @(posedge clk);
		#DRV;
		int_armed = 1'b0;
		axi_write(`CP0_COMPARE_NUM, 3'd0, cnt + 32'd100000);
		axi_read(`CP0_CAUSE_NUM, 3'd0, 1'b1, cause_word(1'b0, 1'b0, 8'd0, 5'd0), d);
		axi_write(`CP0_STATUS_NUM, 3'd0, 32'd0);

		repeat (4) @(posedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	a_aw_w: assert property (@(posedge clk) disable iff (rst)
		awready == wready)
		else begin
			errors++;
			$display("** Error %0t: awready %b, wready %b", $time, awready, wready);
		end
	a_b_next: assert property (@(posedge clk) disable iff (rst)
		(awvalid && awready) |=> bvalid)
		else begin
			errors++;
			$display("** Error %0t: no bvalid after write", $time);
		end
	a_b_cause: assert property (@(posedge clk) disable iff (rst)
		$rose(bvalid) |-> $past(awvalid && awready))
		else begin
			errors++;
			$display("** Error %0t: bvalid without write", $time);
		end
	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		(bvalid && !bready) |=> bvalid)
		else begin
			errors++;
			$display("** Error %0t: bvalid dropped", $time);
		end
	a_bresp: assert property (@(posedge clk) disable iff (rst)
		bvalid |-> (bresp == 2'b00))
		else begin
			errors++;
			$display("** Error %0t: bresp %b, expected OKAY", $time, bresp);
		end
	a_r_next: assert property (@(posedge clk) disable iff (rst)
		(arvalid && arready) |=> rvalid)
		else begin
			errors++;
			$display("** Error %0t: no rvalid after read", $time);
		end
	a_r_cause: assert property (@(posedge clk) disable iff (rst)
		$rose(rvalid) |-> $past(arvalid && arready))
		else begin
			errors++;
			$display("** Error %0t: rvalid without read", $time);
		end
	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		(rvalid && !rready) |=> rvalid)
		else begin
			errors++;
			$display("** Error %0t: rvalid dropped", $time);
		end
	a_rresp: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> (rresp == 2'b00))
		else begin
			errors++;
			$display("** Error %0t: rresp %b, expected OKAY", $time, rresp);
		end
	a_rdata: assert property (@(posedge clk) disable iff (rst)
		(rvalid && rready && rd_chk) |-> (rdata == exp_rdata))
		else begin
			errors++;
			$display("** Error %0t: rdata %h, expected %h", $time, rdata, exp_rdata);
		end
	a_epc: assert property (@(posedge clk) disable iff (rst)
		(rvalid && rready && rd_epc) |-> (epc == exp_rdata))
		else begin
			errors++;
			$display("** Error %0t: epc port %h, expected %h", $time, epc, exp_rdata);
		end
	a_flush_at: assert property (@(posedge clk) disable iff (rst)
		rep.valid |-> ##2 (flush && redirect_pc == exp_redir))
		else begin
			errors++;
			$display("** Error %0t: flush/redirect_pc %h, expected %h", $time,
				redirect_pc, exp_redir);
		end
	a_flush_one: assert property (@(posedge clk) disable iff (rst)
		flush |=> !flush)
		else begin
			errors++;
			$display("** Error %0t: flush longer than a cycle", $time);
		end
	a_int: assert property (@(posedge clk) disable iff (rst)
		int_armed |-> int_pending)
		else begin
			errors++;
			$display("** Error %0t: int_pending low", $time);
		end

	initial begin
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hF;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		rep = '0;
		int_lines = '0;
		rd_chk = 1'b0;
		rd_epc = 1'b0;
		exp_rdata = '0;
		exp_redir = '0;
		int_armed = 1'b0;
		repeat (3) @(posedge clk);
		#DRV;
		rst = 1'b0;

		// scenario end or first timeout, whichever comes first
		fork
			run_scenario();
			wait (timeouts != 0);
		join_any
		finish_run();
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
cp0_pkg.sv
exc_pkg.sv
cp0_axil_slave.sv
exc_prioritizer.sv
cp0_regs.sv
exc_redirect.sv
cp0_top.sv
tb_cp0_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cp0 testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_cp0_top -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_cp0_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
	echo "no pass line in $LOG"
	exit 1
fi
exit 0
